//--- verification/intc_vectors.txt
// test cs rwb addr data irq_line irq_op(1 set, 2 clear) exp_data exp_int exp_vector check
// one bus step per clock, test ff ends the list
// 1 reset values, enable and type byte access
01 1 1 1 00 00 0 00 0 00 1
01 1 1 0 00 00 0 00 0 00 1
01 1 0 0 20 00 0 00 0 00 1
01 1 1 1 00 00 0 00 0 00 1
01 1 0 1 a5 00 0 00 0 00 1
01 1 1 1 00 00 0 a5 0 00 1
01 1 0 0 3f 00 0 00 0 00 1
01 1 0 1 5a 00 0 00 0 00 1
01 1 1 1 00 00 0 5a 0 00 1
01 1 0 0 20 00 0 00 0 00 1
01 1 1 1 00 00 0 a5 0 00 1
01 1 0 0 21 00 0 00 0 00 1
01 1 1 1 00 00 0 00 0 00 1
01 1 0 0 5f 00 0 00 0 00 1
01 1 0 1 c3 00 0 00 0 00 1
01 1 1 1 00 00 0 c3 0 00 1
// 2 masking, line 8 edge and line 9 level enabled while held high
02 1 0 0 41 00 0 00 0 00 1
02 1 0 1 02 00 0 00 0 00 1
02 0 0 0 00 08 1 00 0 00 1
02 0 0 0 00 09 1 00 0 00 1
02 0 0 0 00 00 0 00 0 00 1
02 1 0 0 21 00 0 00 0 00 1
02 1 0 1 03 00 0 00 0 00 1
02 0 0 0 00 00 0 00 0 00 1
02 0 0 0 00 00 0 00 1 09 1
02 0 0 0 00 09 2 00 1 09 1
02 0 0 0 00 08 2 00 0 00 1
02 0 0 0 00 00 0 00 0 00 1
// 3 edge pulse on line 8, pending read, vector read, eoi
03 0 0 0 00 08 1 00 0 00 1
03 0 0 0 00 08 2 00 1 08 1
03 0 0 0 00 00 0 00 1 08 1
03 1 0 0 61 00 0 00 1 08 1
03 1 1 1 00 00 0 01 1 08 1
03 1 0 0 80 00 0 00 1 08 1
03 1 1 1 00 00 0 08 1 08 1
03 1 0 0 a0 00 0 00 1 08 1
03 1 0 1 00 00 0 00 1 08 1
03 1 0 0 61 00 0 00 0 00 1
03 1 1 1 00 00 0 00 0 00 1
// 4 level line 9, eoi while high drops it for one cycle
04 0 0 0 00 09 1 00 0 00 1
04 0 0 0 00 00 0 00 1 09 1
04 1 0 0 a0 00 0 00 1 09 1
04 1 0 1 00 00 0 00 1 09 1
04 0 0 0 00 00 0 00 0 00 1
04 0 0 0 00 00 0 00 1 09 1
04 0 0 0 00 09 2 00 1 09 1
04 0 0 0 00 00 0 00 0 00 1
// 5 priority over lines 3, 100 and 255, eoi walks down
05 1 0 0 5f 00 0 00 0 00 1
05 1 0 1 00 00 0 00 0 00 1
05 1 0 0 20 00 0 00 0 00 1
05 1 0 1 08 00 0 00 0 00 1
05 1 0 0 2c 00 0 00 0 00 1
05 1 0 1 10 00 0 00 0 00 1
05 1 0 0 3f 00 0 00 0 00 1
05 1 0 1 80 00 0 00 0 00 1
05 0 0 0 00 03 1 00 0 00 1
05 0 0 0 00 64 1 00 1 03 1
05 0 0 0 00 ff 1 00 1 64 1
05 1 0 0 80 00 0 00 1 ff 1
05 1 1 1 00 00 0 ff 1 ff 1
05 1 0 0 a0 00 0 00 1 ff 1
05 1 0 1 00 00 0 00 1 ff 1
05 1 0 0 80 00 0 00 1 64 1
05 1 1 1 00 00 0 64 1 64 1
05 1 0 0 a0 00 0 00 1 64 1
05 1 0 1 00 00 0 00 1 64 1
05 1 0 0 80 00 0 00 1 03 1
05 1 1 1 00 00 0 03 1 03 1
05 1 0 0 a0 00 0 00 1 03 1
05 1 0 1 00 00 0 00 1 03 1
05 1 0 0 80 00 0 00 0 00 1
05 1 1 1 00 00 0 00 0 00 1
ff 0 0 0 00 00 0 00 0 00 0

//--- verilog.f
hw/intc_pkg.sv
hw/byte_sel_register.sv
hw/intc_cmd_decoder.sv
hw/irq_pending.sv
hw/irq_priority_encoder.sv
hw/interrupt_controller.sv
verification/intc_checker.sv
verification/tb_interrupt_controller.sv

//--- Makefile
TOP = tb_interrupt_controller

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_interrupt_controller.sv
`timescale 1ns/10ps

module tb_interrupt_controller;

    localparam int NUM_IRQ    = 256;
    localparam int STEP_WORDS = 11;  // hex words per line of the vectors file
    localparam int MAX_STEPS  = 256;
    localparam logic [7:0] END_TEST = 8'hff;

    logic               clk     = 1'b0;
    logic               reset   = 1'b1;
    logic               cs      = 1'b0;
    logic               rwb     = 1'b1;
    logic               addr    = 1'b0;
    logic [7:0]         wr_data = '0;
    logic [NUM_IRQ-1:0] irq     = '0;
    logic [7:0]         rd_data;
    logic               int_req;
    logic [7:0]         vector;

    // expected values travel with the step they belong to
    logic [7:0] test_num   = '0;
    logic [7:0] exp_data   = '0;
    logic       exp_int    = 1'b0;
    logic [7:0] exp_vector = '0;
    logic       check_en   = 1'b0;
    logic       drive_done = 1'b0;

    logic [7:0]         vec_mem [STEP_WORDS*MAX_STEPS];
    logic [NUM_IRQ-1:0] irq_next    = '0; // line levels, one bit changes per step
    int                 num_steps   = 0;
    int                 cycle_limit = 0;
    int                 cycles      = 0;
    int                 step        = 0;
    int                 tests_passed;
    int                 tests_failed;
    int                 check_errors;

    always #5 clk = ~clk;

    interrupt_controller #(
        .NUM_IRQ(NUM_IRQ)
    ) uut (
        .i_clk   (clk),
        .i_reset (reset),
        .i_cs    (cs),
        .i_rwb   (rwb),
        .i_addr  (addr),
        .i_data  (wr_data),
        .o_data  (rd_data),
        .i_irq   (irq),
        .o_int   (int_req),
        .o_vector(vector)
    );

    intc_checker u_checker (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_test        (test_num),
        .i_check       (check_en),
        .i_exp_data    (exp_data),
        .i_exp_int     (exp_int),
        .i_exp_vector  (exp_vector),
        .i_data        (rd_data),
        .i_int         (int_req),
        .i_vector      (vector),
        .o_tests_passed(tests_passed),
        .o_tests_failed(tests_failed),
        .o_errors      (check_errors)
    );

    function automatic int count_steps();
        int         n;
        logic [7:0] tn;
        n = 0;
        while (n < MAX_STEPS) begin
            tn = vec_mem[12'(n*STEP_WORDS)];
            if (tn == END_TEST || tn == 8'h00 || $isunknown(tn)) begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    task automatic apply_step(input int s);
        logic [11:0] base;
        logic [7:0]  line_num;
        logic [7:0]  irq_op;
        base     = 12'(s*STEP_WORDS);
        line_num = vec_mem[base + 12'd5];
        irq_op   = vec_mem[base + 12'd6];
        if (irq_op == 8'd1) begin
            irq_next[line_num] = 1'b1;
        end else if (irq_op == 8'd2) begin
            irq_next[line_num] = 1'b0;
        end
        test_num   <= vec_mem[base];
        cs         <= vec_mem[base + 12'd1][0];
        rwb        <= vec_mem[base + 12'd2][0];
        addr       <= vec_mem[base + 12'd3][0];
        wr_data    <= vec_mem[base + 12'd4];
        irq        <= irq_next;
        exp_data   <= vec_mem[base + 12'd7];
        exp_int    <= vec_mem[base + 12'd8][0];
        exp_vector <= vec_mem[base + 12'd9];
        check_en   <= vec_mem[base + 12'd10][0];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end else if (cycles == 1) begin
            reset <= 1'b0; // seen high at two edges
        end else if (cycles >= 2 && step < num_steps) begin
            apply_step(step);
            step <= step + 1;
        end else if (cycles >= 2 && !drive_done) begin
            cs         <= 1'b0;
            check_en   <= 1'b0;
            test_num   <= END_TEST; // closes the last test
            drive_done <= 1'b1;
        end
    end

    initial begin
        $readmemh("verification/intc_vectors.txt", vec_mem);
        num_steps   = count_steps();
        cycle_limit = num_steps + 20;
        wait (drive_done);
        repeat (2) @(posedge clk);
        $display("tests ok: %0d, tests with errors: %0d, value errors: %0d",
                 tests_passed, tests_failed, check_errors);
        if (num_steps > 0 && tests_failed == 0 && check_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (num_steps == 0) begin
                $display("no steps were read from the vectors file");
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verification/intc_checker.sv
`timescale 1ns/10ps

module intc_checker (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic [7:0] i_test,
    input  logic       i_check,
    input  logic [7:0] i_exp_data,
    input  logic       i_exp_int,
    input  logic [7:0] i_exp_vector,
    input  logic [7:0] i_data,
    input  logic       i_int,
    input  logic [7:0] i_vector,
    output int         o_tests_passed,
    output int         o_tests_failed,
    output int         o_errors
);

    logic [7:0] cur_test    = '0; // 0 until the first step arrives
    int         test_errors = 0;
    int         test_checks = 0;
    int         passed      = 0;
    int         failed      = 0;
    int         errors      = 0;

    assign o_tests_passed = passed;
    assign o_tests_failed = failed;
    assign o_errors       = errors;

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic close_test();
        if (test_checks == 0) begin
            $display("test %0d made no checks", cur_test);
            failed++;
        end else if (test_errors == 0) begin
            $display("test %0d ok, %0d steps checked", cur_test, test_checks);
            passed++;
        end else begin
            $display("test %0d: %0d errors in %0d steps", cur_test, test_errors, test_checks);
            failed++;
        end
    endtask

    // mid-cycle, bus and outputs have settled
    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (i_test !== cur_test) begin
                if (cur_test != 8'd0) begin
                    close_test();
                end
                cur_test    = i_test;
                test_errors = 0;
                test_checks = 0;
            end
            if (i_check === 1'b1) begin
                test_checks++;
                compare("o_data", i_exp_data, i_data);
                compare("o_int", {7'd0, i_exp_int}, {7'd0, i_int});
                compare("o_vector", i_exp_vector, i_vector);
            end
        end
    end

endmodule

//--- hw/interrupt_controller.sv
`timescale 1ns/10ps

module interrupt_controller
    import intc_pkg::*;
#(
    parameter int NUM_IRQ = 256
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_cs,
    input  logic                  i_rwb,
    input  logic                  i_addr,
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic [DATA_WIDTH-1:0] o_data,
    input  logic [NUM_IRQ-1:0]    i_irq,
    output logic                  o_int,
    output logic [VEC_WIDTH-1:0]  o_vector
);

    localparam int NUM_BYTES = NUM_IRQ / 8;

    logic                     enable_write;
    logic                     type_write;
    logic                     eoi;
    logic [CMD_BYTE_BITS-1:0] byte_sel;
    logic [DATA_WIDTH-1:0]    enable_byte;
    logic [DATA_WIDTH-1:0]    type_byte;
    logic [NUM_IRQ-1:0]       enable_mask;
    logic [NUM_IRQ-1:0]       type_mask;
    logic [NUM_IRQ-1:0]       pending;

    byte_sel_register #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_BYTES (NUM_BYTES)
    ) reg_enable (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_write    (enable_write),
        .i_byte_sel (byte_sel),
        .i_data     (i_data),
        .o_data     (enable_byte),
        .o_full_data(enable_mask)
    );

    // 1 = level triggered
    byte_sel_register #(
        .DATA_WIDTH(DATA_WIDTH),
        .NUM_BYTES (NUM_BYTES)
    ) reg_type (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_write    (type_write),
        .i_byte_sel (byte_sel),
        .i_data     (i_data),
        .o_data     (type_byte),
        .o_full_data(type_mask)
    );

    intc_cmd_decoder #(
        .NUM_IRQ(NUM_IRQ)
    ) u_decoder (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_cs          (i_cs),
        .i_rwb         (i_rwb),
        .i_addr        (i_addr),
        .i_data        (i_data),
        .i_enable_byte (enable_byte),
        .i_type_byte   (type_byte),
        .i_pending     (pending),
        .i_vector      (o_vector),
        .o_enable_write(enable_write),
        .o_type_write  (type_write),
        .o_eoi         (eoi),
        .o_byte_sel    (byte_sel),
        .o_data        (o_data)
    );

    irq_pending #(
        .NUM_IRQ(NUM_IRQ)
    ) u_pending (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_eoi    (eoi),
        .i_irq    (i_irq),
        .i_enable (enable_mask),
        .i_type   (type_mask),
        .i_vector (o_vector), // eoi targets the vector shown this cycle
        .o_pending(pending)
    );

    irq_priority_encoder #(
        .NUM_IRQ(NUM_IRQ)
    ) u_encoder (
        .i_pending(pending),
        .o_vector (o_vector),
        .o_int    (o_int)
    );

endmodule

//--- hw/irq_priority_encoder.sv
`timescale 1ns/10ps

module irq_priority_encoder
    import intc_pkg::*;
#(
    parameter int NUM_IRQ = 256
) (
    input  logic [NUM_IRQ-1:0]   i_pending,
    output logic [VEC_WIDTH-1:0] o_vector,
    output logic                 o_int
);

    // scan upward so the highest set bit is the last one kept
    always_comb begin
        o_vector = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (i_pending[i]) begin
                o_vector = VEC_WIDTH'(i);
            end
        end
    end

    // line 0 alone still raises the request
    assign o_int = |i_pending;

endmodule

//--- hw/irq_pending.sv
`timescale 1ns/10ps

module irq_pending
    import intc_pkg::*;
#(
    parameter int NUM_IRQ = 256
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_eoi,
    input  logic [NUM_IRQ-1:0]   i_irq,
    input  logic [NUM_IRQ-1:0]   i_enable,
    input  logic [NUM_IRQ-1:0]   i_type,
    input  logic [VEC_WIDTH-1:0] i_vector,
    output logic [NUM_IRQ-1:0]   o_pending
);

    logic [NUM_IRQ-1:0] irq_q;      // input as seen at the previous edge
    logic [NUM_IRQ-1:0] pending_q;
    logic [NUM_IRQ-1:0] pending_d;
    logic [NUM_IRQ-1:0] eoi_mask;
    logic [NUM_IRQ-1:0] rise;
    logic [NUM_IRQ-1:0] edge_next;
    logic [NUM_IRQ-1:0] level_next;

    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            eoi_mask[i] = i_eoi && (int'(i_vector) == i);
        end
    end

    assign rise = i_irq & ~irq_q;

    // edge lines hold until eoi, a fresh edge beats the eoi
    assign edge_next = (pending_q & ~eoi_mask) | rise;

    // level lines just track the input, eoi drops them for one edge
    assign level_next = i_irq & ~eoi_mask;

    assign pending_d = ((i_type & level_next) | (~i_type & edge_next)) & i_enable;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            irq_q     <= '0;
            pending_q <= '0;
        end else begin
            irq_q     <= i_irq;
            pending_q <= pending_d;
        end
    end

    assign o_pending = pending_q;

endmodule

//--- hw/intc_cmd_decoder.sv
`timescale 1ns/10ps

module intc_cmd_decoder
    import intc_pkg::*;
#(
    parameter int NUM_IRQ = 256
) (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_cs,
    input  logic                     i_rwb,
    input  logic                     i_addr,
    input  logic [DATA_WIDTH-1:0]    i_data,
    input  logic [DATA_WIDTH-1:0]    i_enable_byte,
    input  logic [DATA_WIDTH-1:0]    i_type_byte,
    input  logic [NUM_IRQ-1:0]       i_pending,
    input  logic [VEC_WIDTH-1:0]     i_vector,
    output logic                     o_enable_write,
    output logic                     o_type_write,
    output logic                     o_eoi,
    output logic [CMD_BYTE_BITS-1:0] o_byte_sel,
    output logic [DATA_WIDTH-1:0]    o_data
);

    localparam int PEND_BYTES = NUM_IRQ / DATA_WIDTH;

    logic [CMD_WIDTH-1:0]     cmd_q;
    cmd_op_e                  cmd_op;
    logic [CMD_BYTE_BITS-1:0] byte_sel;
    logic                     bus_wr;
    logic                     bus_rd;
    logic                     data_wr;
    logic [DATA_WIDTH-1:0]    pending_byte;
    logic [DATA_WIDTH-1:0]    rd_mux;

    assign bus_wr  = i_cs & ~i_rwb;
    assign bus_rd  = i_cs & i_rwb;
    assign data_wr = bus_wr & i_addr;

    // command byte lives at address 0, write only
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cmd_q <= {CMD_NOP, {CMD_BYTE_BITS{1'b0}}};
        end else if (bus_wr && !i_addr) begin
            cmd_q <= i_data[CMD_WIDTH-1:0];
        end
    end

    assign cmd_op   = cmd_op_e'(cmd_q[CMD_OP_LSB +: CMD_OP_BITS]);
    assign byte_sel = cmd_q[CMD_BYTE_LSB +: CMD_BYTE_BITS];

    assign o_byte_sel     = byte_sel;
    assign o_enable_write = data_wr && (cmd_op == CMD_ENABLE);
    assign o_type_write   = data_wr && (cmd_op == CMD_TYPE);
    assign o_eoi          = data_wr && (cmd_op == CMD_EOI); // data value is don't care

    always_comb begin
        pending_byte = '0;
        if (int'(byte_sel) < PEND_BYTES) begin
            pending_byte = i_pending[byte_sel*DATA_WIDTH +: DATA_WIDTH];
        end
    end

    always_comb begin
        case (cmd_op)
            CMD_ENABLE:  rd_mux = i_enable_byte;
            CMD_TYPE:    rd_mux = i_type_byte;
            CMD_PENDING: rd_mux = pending_byte;
            CMD_VECTOR:  rd_mux = i_vector;
            default:     rd_mux = '0; // nop, eoi and spare codes
        endcase
    end

    assign o_data = (bus_rd && i_addr) ? rd_mux : '0;

endmodule

//--- hw/byte_sel_register.sv
`timescale 1ns/10ps

module byte_sel_register
    import intc_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int NUM_BYTES  = 32
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_write,
    input  logic [CMD_BYTE_BITS-1:0]        i_byte_sel,
    input  logic [DATA_WIDTH-1:0]           i_data,
    output logic [DATA_WIDTH-1:0]           o_data,
    output logic [DATA_WIDTH*NUM_BYTES-1:0] o_full_data
);

    logic [DATA_WIDTH-1:0] bank [NUM_BYTES];
    logic                  sel_valid;

    assign sel_valid = (int'(i_byte_sel) < NUM_BYTES);

    // masks must come up cleared
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                bank[i] <= '0;
            end
        end else if (i_write && sel_valid) begin
            bank[i_byte_sel] <= i_data;
        end
    end

    assign o_data = sel_valid ? bank[i_byte_sel] : '0;

    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            o_full_data[i*DATA_WIDTH +: DATA_WIDTH] = bank[i];
        end
    end

endmodule

//--- hw/intc_pkg.sv
package intc_pkg;

    // bus and register byte
    localparam int DATA_WIDTH = 8;

    // vector number, wide enough for 256 lines
    localparam int VEC_WIDTH = 8;

    // command byte layout, opcode on top of the byte index
    localparam int CMD_BYTE_BITS = 5;
    localparam int CMD_OP_BITS   = 3;
    localparam int CMD_BYTE_LSB  = 0;
    localparam int CMD_OP_LSB    = CMD_BYTE_LSB + CMD_BYTE_BITS;
    localparam int CMD_WIDTH     = CMD_OP_BITS + CMD_BYTE_BITS;

    // codes 6 and 7 fall through to nop
    typedef enum logic [CMD_OP_BITS-1:0] {
        CMD_NOP     = 3'd0,
        CMD_ENABLE  = 3'd1,
        CMD_TYPE    = 3'd2, // 1 = level, 0 = edge
        CMD_PENDING = 3'd3,
        CMD_VECTOR  = 3'd4,
        CMD_EOI     = 3'd5
    } cmd_op_e;

endpackage
